//--- saturn_bus_pkg.sv
package saturn_bus_pkg;

    // One bus nibble
    typedef logic [3:0]  nibble_t;

    // Nibble address, sent least significant nibble first
    typedef logic [19:0] addr_t;
    localparam int ADDR_NIBBLES = 5;

    // Program list entry, bit 4 set for a command
    typedef logic [4:0]  prog_entry_t;

    localparam int PROG_DEPTH = 32;
    typedef logic [4:0]  prog_idx_t;     // Wraps at PROG_DEPTH

    // Command nibbles
    localparam nibble_t CMD_LOAD_ADDR = 4'h4;  // Next 5 data nibbles load the pointer
    localparam nibble_t CMD_WRITE     = 4'h5;  // Data nibbles written, pointer steps
    localparam nibble_t CMD_READ      = 4'h6;  // Read strobes return data, pointer steps

    // One-hot bus phases
    localparam logic [3:0] PH_SEND   = 4'b0001;  // Command or data out
    localparam logic [3:0] PH_READ   = 4'b0010;  // Devices act, read captured
    localparam logic [3:0] PH_DECODE = 4'b0100;
    localparam logic [3:0] PH_EXEC   = 4'b1000;

    // Largest request, in nibbles
    localparam int MAX_LEN = 4;

endpackage

//--- saturn_dev_pkg.sv
package saturn_dev_pkg;

    localparam int NUM_DEV     = 4;   // Memory devices on the bus
    localparam int DEV_NIBBLES = 16;  // Store size of each
    localparam int DEV_OFS_W   = $clog2(DEV_NIBBLES);

    // Device k starts at DEV_BASE_0 + k * DEV_NIBBLES
    localparam saturn_bus_pkg::addr_t DEV_BASE_0 = 20'h00100;

endpackage

//--- saturn_phase_gen.sv
module saturn_phase_gen
    import saturn_bus_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    output logic [3:0]  o_phases,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_phases    <= PH_SEND;     // Bus cycle starts on the send phase
            o_phase     <= 2'd0;
            o_cycle_ctr <= '0;
        end else begin
            o_phases <= {o_phases[2:0], o_phases[3]};  // Rotate left
            o_phase  <= o_phase + 2'd1;                 // Index follows the one-hot bit
            // One more full cycle after the last phase
            if (o_phases == PH_EXEC) begin
                o_cycle_ctr <= o_cycle_ctr + 32'd1;
            end
        end
    end

endmodule

//--- saturn_cmd_sequencer.sv
module saturn_cmd_sequencer
    import saturn_bus_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic [3:0]           i_phases,
    input  logic                 i_req,
    input  logic                 i_req_write,
    input  addr_t                i_req_addr,
    input  logic [2:0]           i_req_len,
    input  logic [4*MAX_LEN-1:0] i_req_wdata,
    input  prog_idx_t            i_prog_rd_idx,
    input  logic                 i_read_valid,
    input  nibble_t              i_read_nibble,
    input  logic                 i_halt,
    output prog_idx_t            o_prog_wr_idx,
    output prog_entry_t          o_prog_data,
    output logic                 o_no_read,
    output logic                 o_busy,
    output logic                 o_done,
    output logic [4*MAX_LEN-1:0] o_rdata
);

    typedef enum logic [2:0] {S_IDLE, S_LOAD, S_ADDR, S_OP, S_DATA, S_WAIT} state_t;

    state_t               state;
    prog_entry_t          prog_mem [PROG_DEPTH];
    addr_t                req_addr;      // Latched request
    logic                 req_write;
    logic [2:0]           req_len;
    logic [4*MAX_LEN-1:0] req_wdata;
    logic [2:0]           nib_cnt;       // Address or data nibble being queued
    logic [2:0]           beat_cnt;      // Read beats seen
    prog_entry_t          entry;
    logic                 entry_en;
    logic                 accept;
    logic                 drained;
    logic                 beat_fail;

    assign accept      = i_req && !o_busy;
    assign o_prog_data = prog_mem[i_prog_rd_idx];   // Controller reads at its own index
    assign drained     = (o_prog_wr_idx == i_prog_rd_idx);

    // Halted controller sends no strobe, so each send slot is a lost beat
    assign beat_fail = i_halt && !o_no_read && drained && (i_phases == PH_SEND);

    // Entry queued this clock
    always_comb begin
        entry_en = 1'b1;
        entry    = '0;
        case (state)
            S_LOAD:  entry = {1'b1, CMD_LOAD_ADDR};
            S_ADDR:  entry = {1'b0, req_addr[nib_cnt*4 +: 4]};     // LSN first
            S_OP:    entry = {1'b1, (req_write ? CMD_WRITE : CMD_READ)};
            S_DATA:  entry = {1'b0, req_wdata[nib_cnt*4 +: 4]};
            default: entry_en = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (entry_en) begin
            prog_mem[o_prog_wr_idx] <= entry;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= S_IDLE;
            o_prog_wr_idx <= '0;        // List empty
            nib_cnt       <= '0;
            beat_cnt      <= '0;
            o_no_read     <= 1'b1;
            o_busy        <= 1'b0;
            o_done        <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (entry_en) begin
                o_prog_wr_idx <= o_prog_wr_idx + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state  <= S_LOAD;
                        o_busy <= 1'b1;
                    end
                end
                S_LOAD: begin
                    nib_cnt <= '0;
                    state   <= S_ADDR;
                end
                S_ADDR: begin
                    nib_cnt <= nib_cnt + 3'd1;
                    if (nib_cnt == 3'(ADDR_NIBBLES - 1)) begin
                        state <= S_OP;
                    end
                end
                S_OP: begin
                    nib_cnt   <= '0;
                    beat_cnt  <= '0;
                    o_no_read <= req_write;   // Reads may start once queued
                    state     <= req_write ? S_DATA : S_WAIT;
                end
                S_DATA: begin
                    nib_cnt <= nib_cnt + 3'd1;
                    if (nib_cnt == req_len - 3'd1) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if ((i_read_valid || beat_fail) && beat_cnt < req_len) begin
                        beat_cnt <= beat_cnt + 3'd1;
                    end
                    if (drained && (o_no_read || beat_cnt == req_len)) begin
                        state     <= S_IDLE;
                        o_no_read <= 1'b1;
                        o_busy    <= 1'b0;
                        o_done    <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request payload and read assembly; lost beats keep their cleared nibble
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_addr  <= i_req_addr;
            req_write <= i_req_write;
            req_len   <= i_req_len;
            req_wdata <= i_req_wdata;
            o_rdata   <= '0;
        end else if (i_read_valid && beat_cnt < req_len) begin
            o_rdata[beat_cnt*4 +: 4] <= i_read_nibble;
        end
    end

endmodule

//--- saturn_bus_controller.sv
module saturn_bus_controller
    import saturn_bus_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic [3:0]  i_phases,
    input  prog_idx_t   i_prog_wr_idx,
    input  prog_entry_t i_prog_data,
    input  logic        i_no_read,
    input  nibble_t     i_bus_nibble_in,
    input  logic        i_bus_hit,
    input  logic        i_bus_conflict,
    output prog_idx_t   o_prog_rd_idx,
    output logic        o_bus_clk_en,
    output logic        o_bus_is_cmd,
    output logic        o_bus_is_data,
    output nibble_t     o_bus_nibble_out,
    output logic        o_read_valid,
    output nibble_t     o_read_nibble,
    output logic        o_halt
);

    logic more_to_send;
    logic read_strobe;   // Current beat is a read
    logic capture;

    assign more_to_send = (o_prog_rd_idx != i_prog_wr_idx);
    assign read_strobe  = o_bus_clk_en && !o_bus_is_cmd && !o_bus_is_data;
    assign capture      = (i_phases == PH_READ) && read_strobe;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_prog_rd_idx <= '0;
            o_bus_clk_en  <= 1'b0;
            o_bus_is_cmd  <= 1'b0;
            o_bus_is_data <= 1'b0;
            o_read_valid  <= 1'b0;
            o_halt        <= 1'b0;   // Bus error clears only here
        end else begin
            o_read_valid <= 1'b0;
            case (i_phases)
                PH_SEND: begin
                    if (more_to_send) begin
                        o_prog_rd_idx <= o_prog_rd_idx + 1'b1;
                        o_bus_is_cmd  <= i_prog_data[4];
                        o_bus_is_data <= !i_prog_data[4];
                        o_bus_clk_en  <= 1'b1;
                    end else if (!i_no_read && !o_halt) begin
                        // List empty, set up a read
                        o_bus_is_cmd  <= 1'b0;
                        o_bus_is_data <= 1'b0;
                        o_bus_clk_en  <= 1'b1;
                    end
                end
                PH_READ: begin
                    o_bus_clk_en <= 1'b0;
                    if (capture) begin
                        if (!i_bus_hit || i_bus_conflict) begin
                            o_halt <= 1'b1;        // Unmapped or contested
                        end else begin
                            o_read_valid <= 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Bus payload
    always_ff @(posedge i_clk) begin
        if (i_phases == PH_SEND && more_to_send) begin
            o_bus_nibble_out <= i_prog_data[3:0];
        end
        if (capture) begin
            o_read_nibble <= i_bus_nibble_in;
        end
    end

endmodule

//--- saturn_nibble_device.sv
module saturn_nibble_device
    import saturn_bus_pkg::*;
    import saturn_dev_pkg::*;
#(
    parameter addr_t P_BASE = DEV_BASE_0
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic [3:0] i_phases,
    input  logic       i_bus_clk_en,
    input  logic       i_bus_is_cmd,
    input  logic       i_bus_is_data,
    input  nibble_t    i_bus_nibble,
    output nibble_t    o_nibble,
    output logic       o_hit
);

    typedef enum logic [1:0] {M_IDLE, M_ADDR, M_WRITE, M_READ} mode_t;

    mode_t      mode;
    addr_t      ptr;        // Private copy of the bus address
    addr_t      rel;
    logic [2:0] addr_cnt;   // Address nibbles loaded
    logic       act;
    logic       strobe;
    logic       in_range;
    nibble_t    mem [DEV_NIBBLES];

    assign act      = i_bus_clk_en && (i_phases == PH_READ);
    assign strobe   = !i_bus_is_cmd && !i_bus_is_data;
    assign rel      = ptr - P_BASE;                     // Wraps high below base
    assign in_range = (rel < addr_t'(DEV_NIBBLES));
    assign o_hit    = act && strobe && (mode == M_READ) && in_range;
    assign o_nibble = o_hit ? mem[rel[DEV_OFS_W-1:0]] : '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode     <= M_IDLE;
            ptr      <= '0;
            addr_cnt <= '0;
        end else if (act) begin
            if (i_bus_is_cmd) begin
                addr_cnt <= '0;
                case (i_bus_nibble)
                    CMD_LOAD_ADDR: mode <= M_ADDR;
                    CMD_WRITE:     mode <= M_WRITE;
                    CMD_READ:      mode <= M_READ;
                    default:       mode <= M_IDLE;
                endcase
            end else if (mode == M_ADDR) begin
                if (i_bus_is_data) begin
                    ptr[addr_cnt*4 +: 4] <= i_bus_nibble;
                    addr_cnt <= addr_cnt + 3'd1;
                    if (addr_cnt == 3'(ADDR_NIBBLES - 1)) begin
                        mode <= M_IDLE;   // Full address in
                    end
                end
            end else if ((mode == M_WRITE && i_bus_is_data) || (mode == M_READ && strobe)) begin
                ptr <= ptr + 1'b1;   // Steps even when out of range
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (act && i_bus_is_data && mode == M_WRITE && in_range) begin
            mem[rel[DEV_OFS_W-1:0]] <= i_bus_nibble;
        end
    end

endmodule

//--- saturn_bus_merge.sv
module saturn_bus_merge
    import saturn_bus_pkg::*;
    import saturn_dev_pkg::*;
(
    input  nibble_t [NUM_DEV-1:0] i_dev_nibble,
    input  logic    [NUM_DEV-1:0] i_dev_hit,
    output nibble_t               o_bus_nibble,
    output logic                  o_bus_hit,
    output logic                  o_bus_conflict
);

    always_comb begin
        o_bus_nibble   = '0;
        o_bus_hit      = 1'b0;
        o_bus_conflict = 1'b0;
        for (int k = 0; k < NUM_DEV; k++) begin
            if (i_dev_hit[k]) begin
                if (o_bus_hit) begin
                    o_bus_conflict = 1'b1;   // Second responder
                end
                o_bus_hit    = 1'b1;
                o_bus_nibble = i_dev_nibble[k];
            end
        end
    end

endmodule

//--- saturn_bus_top.sv
module saturn_bus_top
    import saturn_bus_pkg::*;
    import saturn_dev_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_req,
    input  logic                 i_req_write,
    input  addr_t                i_req_addr,
    input  logic [2:0]           i_req_len,
    input  logic [4*MAX_LEN-1:0] i_req_wdata,
    output logic                 o_busy,
    output logic                 o_done,
    output logic [4*MAX_LEN-1:0] o_rdata,
    output logic                 o_halt
);

    logic [3:0]            phases;
    prog_idx_t             prog_wr_idx;
    prog_idx_t             prog_rd_idx;
    prog_entry_t           prog_data;
    logic                  no_read;
    logic                  bus_clk_en;
    logic                  bus_is_cmd;
    logic                  bus_is_data;
    nibble_t               bus_nibble_out;
    nibble_t               bus_nibble_in;
    logic                  bus_hit;
    logic                  bus_conflict;
    logic                  read_valid;
    nibble_t               read_nibble;
    nibble_t [NUM_DEV-1:0] dev_nibble;
    logic    [NUM_DEV-1:0] dev_hit;

    saturn_phase_gen u_phase_gen (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .o_phases    (phases),
        .o_phase     (),
        .o_cycle_ctr ()
    );

    saturn_cmd_sequencer u_sequencer (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_phases      (phases),
        .i_req         (i_req),
        .i_req_write   (i_req_write),
        .i_req_addr    (i_req_addr),
        .i_req_len     (i_req_len),
        .i_req_wdata   (i_req_wdata),
        .i_prog_rd_idx (prog_rd_idx),
        .i_read_valid  (read_valid),
        .i_read_nibble (read_nibble),
        .i_halt        (o_halt),
        .o_prog_wr_idx (prog_wr_idx),
        .o_prog_data   (prog_data),
        .o_no_read     (no_read),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_rdata       (o_rdata)
    );

    saturn_bus_controller u_bus_ctrl (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_phases         (phases),
        .i_prog_wr_idx    (prog_wr_idx),
        .i_prog_data      (prog_data),
        .i_no_read        (no_read),
        .i_bus_nibble_in  (bus_nibble_in),
        .i_bus_hit        (bus_hit),
        .i_bus_conflict   (bus_conflict),
        .o_prog_rd_idx    (prog_rd_idx),
        .o_bus_clk_en     (bus_clk_en),
        .o_bus_is_cmd     (bus_is_cmd),
        .o_bus_is_data    (bus_is_data),
        .o_bus_nibble_out (bus_nibble_out),
        .o_read_valid     (read_valid),
        .o_read_nibble    (read_nibble),
        .o_halt           (o_halt)
    );

    // Device k sits DEV_NIBBLES above device k-1
    for (genvar k = 0; k < NUM_DEV; k++) begin : g_dev
        saturn_nibble_device #(
            .P_BASE (DEV_BASE_0 + addr_t'(k * DEV_NIBBLES))
        ) u_dev (
            .i_clk         (i_clk),
            .i_reset       (i_reset),
            .i_phases      (phases),
            .i_bus_clk_en  (bus_clk_en),
            .i_bus_is_cmd  (bus_is_cmd),
            .i_bus_is_data (bus_is_data),
            .i_bus_nibble  (bus_nibble_out),
            .o_nibble      (dev_nibble[k]),
            .o_hit         (dev_hit[k])
        );
    end

    saturn_bus_merge u_merge (
        .i_dev_nibble   (dev_nibble),
        .i_dev_hit      (dev_hit),
        .o_bus_nibble   (bus_nibble_in),
        .o_bus_hit      (bus_hit),
        .o_bus_conflict (bus_conflict)
    );

endmodule

//--- saturn_bus_props.sv
module saturn_bus_props
    import saturn_bus_pkg::*;
(
    input logic       i_clk,
    input logic       i_reset,
    input logic [3:0] i_phases,
    input logic       i_bus_clk_en,
    input logic       i_bus_is_cmd,
    input logic       i_bus_is_data,
    input logic       i_halt
);

    // Clock enable only goes high off a send phase edge
    clk_en_rise_in_send: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_bus_clk_en) |-> ($past(i_phases) == PH_SEND))
        else $error("bus clock enable rose outside the send phase");

    // A beat is command, data or read strobe, never both flags
    cmd_data_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_bus_is_cmd && i_bus_is_data))
        else $error("command and data flags high together");

    halt_sticky: assert property (@(posedge i_clk) disable iff (i_reset)
        i_halt |=> i_halt)   // Bus error held until reset
        else $error("halt dropped without a reset");

endmodule

bind saturn_bus_controller saturn_bus_props u_props (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_phases      (i_phases),
    .i_bus_clk_en  (o_bus_clk_en),
    .i_bus_is_cmd  (o_bus_is_cmd),
    .i_bus_is_data (o_bus_is_data),
    .i_halt        (o_halt)
);

//--- tb_saturn_bus.sv
module tb_saturn_bus
    import saturn_bus_pkg::*;
    import saturn_dev_pkg::*;
();

    localparam int DONE_LIMIT = 400;                  // Clocks allowed for one request
    localparam int WATCHDOG   = 5 * 20 * 4 * 20 * 4;  // Tests, cycles, clocks, period, margin

    logic                 i_clk;
    logic                 i_reset;
    logic                 i_req;
    logic                 i_req_write;
    addr_t                i_req_addr;
    logic [2:0]           i_req_len;
    logic [4*MAX_LEN-1:0] i_req_wdata;
    logic                 o_busy;
    logic                 o_done;
    logic [4*MAX_LEN-1:0] o_rdata;
    logic                 o_halt;

    integer               seed;
    int                   value_errs;   // Wrong values
    int                   other_errs;   // Timeouts
    logic [4*MAX_LEN-1:0] first_data;   // Written in test 1 and reread after reset

    saturn_bus_top DUT (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_req_write (i_req_write),
        .i_req_addr  (i_req_addr),
        .i_req_len   (i_req_len),
        .i_req_wdata (i_req_wdata),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_rdata     (o_rdata),
        .o_halt      (o_halt)
    );

    always #10 i_clk = ~i_clk;

    task automatic check_word(input logic [4*MAX_LEN-1:0] got,
                              input logic [4*MAX_LEN-1:0] exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_nibble(input nibble_t got, input nibble_t exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Nibbles above the requested length read as zero
    function automatic logic [4*MAX_LEN-1:0] keep_low_nibbles(
        input logic [4*MAX_LEN-1:0] data, input int len);
        return data & ((16'h1 << (4 * len)) - 16'h1);
    endfunction

    task automatic apply_reset();
        @(posedge i_clk);
        i_reset <= 1'b1;
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    // Pulse one request for a single clock
    task automatic send_req(input logic wr, input addr_t addr, input logic [2:0] len,
                            input logic [4*MAX_LEN-1:0] wdata);
        @(posedge i_clk);
        i_req       <= 1'b1;
        i_req_write <= wr;
        i_req_addr  <= addr;
        i_req_len   <= len;
        i_req_wdata <= wdata;
        @(posedge i_clk);
        i_req <= 1'b0;                   // One-clock pulse
    endtask

    // Wait for the done pulse and sample halt with it
    task automatic wait_done(input addr_t addr, output logic halt_at_done);
        int n;
        n = 0;
        @(negedge i_clk);
        while (!o_done && n < DONE_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_done) begin
            other_errs++;
            $display("Request at address %h never signalled done (time %0t)", addr, $time);
        end
        halt_at_done = o_halt;
    endtask

    task automatic run_req(input logic wr, input addr_t addr, input logic [2:0] len,
                           input logic [4*MAX_LEN-1:0] wdata, output logic halt_at_done);
        send_req(wr, addr, len, wdata);
        wait_done(addr, halt_at_done);
    endtask

    task automatic test_write_read();
        logic halt;
        first_data = 16'($random(seed));
        run_req(1'b1, 20'h00104, 3'd4, first_data, halt);
        run_req(1'b0, 20'h00104, 3'd4, '0, halt);
        check_word(o_rdata, first_data, "read back at 00104");
        check_flag(halt, 1'b0, "halt after mapped read");
    endtask

    task automatic test_cross_device();
        logic                 halt;
        logic [4*MAX_LEN-1:0] data;
        data = 16'($random(seed));
        run_req(1'b1, 20'h0010E, 3'd4, data, halt);   // 10E,10F in dev 0; 110,111 in dev 1
        run_req(1'b0, 20'h0010E, 3'd4, '0, halt);
        check_word(o_rdata, data, "read back at 0010E");
        check_nibble(DUT.g_dev[0].u_dev.mem[14], data[3:0], "dev 0 offset E");
        check_nibble(DUT.g_dev[0].u_dev.mem[15], data[7:4], "dev 0 offset F");
        check_nibble(DUT.g_dev[1].u_dev.mem[0], data[11:8], "dev 1 offset 0");
        check_nibble(DUT.g_dev[1].u_dev.mem[1], data[15:12], "dev 1 offset 1");
        check_flag(halt, 1'b0, "halt after boundary read");
    endtask

    task automatic test_short_writes();
        logic                 halt;
        logic [4*MAX_LEN-1:0] data [3];
        for (int i = 0; i < 3; i++) begin
            data[i] = keep_low_nibbles(16'($random(seed)), i + 1);
            run_req(1'b1, 20'h00120 + addr_t'(4 * i), 3'(i + 1), data[i], halt);
        end
        // All three read after the last write
        for (int i = 0; i < 3; i++) begin
            run_req(1'b0, 20'h00120 + addr_t'(4 * i), 3'(i + 1), '0, halt);
            check_word(o_rdata, data[i], $sformatf("short read of length %0d", i + 1));
        end
    endtask

    task automatic test_unmapped_read();
        logic halt;
        run_req(1'b0, 20'h00000, 3'd2, '0, halt);
        check_flag(halt, 1'b1, "halt at done of unmapped read");  // Done came after the failures
        check_word(o_rdata, '0, "unmapped read data");
        check_flag(o_busy, 1'b0, "busy after unmapped read");
    endtask

    task automatic test_reset_keeps_data();
        logic halt;
        send_req(1'b0, 20'h00104, 3'd4, '0);   // Reset lands mid-request
        @(negedge i_clk);
        check_flag(o_busy, 1'b1, "busy before reset");
        apply_reset();
        @(negedge i_clk);
        check_flag(o_halt, 1'b0, "halt after reset");
        check_flag(o_busy, 1'b0, "busy after reset");
        run_req(1'b0, 20'h00104, 3'd4, '0, halt);
        check_word(o_rdata, first_data, "read at 00104 after reset");
        check_flag(halt, 1'b0, "halt on read after reset");
    endtask

    initial begin
        seed        = 32'h4639_31ca;
        value_errs  = 0;
        other_errs  = 0;
        first_data  = '0;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_req       = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = '0;
        i_req_len   = '0;
        i_req_wdata = '0;
        apply_reset();
        test_write_read();
        test_cross_device();
        test_short_writes();
        test_unmapped_read();
        test_reset_keeps_data();
        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- saturn_bus.f
saturn_bus_pkg.sv
saturn_dev_pkg.sv
saturn_phase_gen.sv
saturn_cmd_sequencer.sv
saturn_bus_controller.sv
saturn_nibble_device.sv
saturn_bus_merge.sv
saturn_bus_top.sv
saturn_bus_props.sv
tb_saturn_bus.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_saturn_bus \
    -f saturn_bus.f -o sim_saturn_bus > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_saturn_bus > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
